//--- dv/sbox_patterns.txt
// Columns: test number, mode (1 = decrypt), input byte, expected byte, all hex
// Tests: 1 forward, 2 inverse, 3 mixed mode, 4 random hold, 5 overflow
1 0 00 63
1 0 53 ED
1 0 FF 16
1 0 7F D2
2 1 63 00
2 1 ED 53
2 1 16 FF
2 1 D2 7F
3 0 11 82
3 1 82 11
3 0 9A B8
3 1 DD C9
4 0 3C EB
4 0 C9 DD
4 0 45 6E
4 1 0C 81
5 0 01 7C
5 0 02 77
5 0 03 7B
5 0 04 F2
5 0 05 6B
5 0 06 6F
5 0 07 C5
5 0 08 30
5 0 09 01
5 0 0A 67
5 0 0B 2B
5 0 0C FE

//--- dv/tb_sbox_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sbox_subsystem;

    localparam int NUM_LINES       = 28;
    localparam int FIELDS          = 4;
    localparam int CYCLES_PER_LINE = 200;
    localparam int HOLD_TEST       = 4;
    localparam int OVERFLOW_TEST   = 5;

    logic                clock;
    logic                rst_n;
    logic                valid;
    gf_field_pkg::byte_t data;
    logic                decrypt;
    logic                hold;
    gf_field_pkg::word_t word;
    logic                word_valid;
    logic                overflow;

    gf_field_pkg::byte_t patterns [NUM_LINES*FIELDS];
    gf_field_pkg::word_t exp_words [$];
    int                  exp_tests [$];
    gf_field_pkg::word_t partial_word;
    int                  partial_bytes;
    logic [31:0]         rng_state;
    gf_field_pkg::word_t got_word;
    int                  got_test;

    sbox_subsystem_top dut (
        .i_clock      (clock),
        .i_rst_n      (rst_n),
        .i_valid      (valid),
        .i_data       (data),
        .i_decrypt    (decrypt),
        .i_hold       (hold),
        .o_word       (word),
        .o_word_valid (word_valid),
        .o_overflow   (overflow)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] next_random(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string test_name(int t);
        case (t)
            1: return "forward_sbox";
            2: return "inverse_sbox";
            3: return "mixed_mode";
            4: return "back_pressure";
            5: return "overflow";
            default: return "unknown";
        endcase
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, gf_field_pkg::word_t expected,
                               gf_field_pkg::word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // First byte of a word ends up in the top bits
    task automatic expect_byte(int test, gf_field_pkg::byte_t b);
        int pos;
        pos = (gf_field_pkg::BYTES_PER_WORD - 1 - partial_bytes) * gf_field_pkg::NB_BYTE;
        partial_word[pos +: gf_field_pkg::NB_BYTE] = b;
        partial_bytes++;
        if (partial_bytes == gf_field_pkg::BYTES_PER_WORD) begin
            exp_words.push_back(partial_word);
            exp_tests.push_back(test);
            partial_bytes = 0;
        end
    endtask

    task automatic wait_drained();
        while (exp_words.size() != 0) begin
            @(negedge clock);
        end
    endtask

    always @(negedge clock) begin
        if (rst_n && word_valid) begin
            if (exp_words.size() == 0) begin
                abort_run($sformatf("Word %h arrived while no word was expected", word));
            end else begin
                got_word = exp_words.pop_front();
                got_test = exp_tests.pop_front();
                check_value(test_name(got_test), got_word, word);
            end
        end
    end

    initial begin
        repeat (NUM_LINES * CYCLES_PER_LINE) @(posedge clock);
        abort_run("Timeout: the expected words did not arrive in time");
    end

    initial begin
        int                  test;
        int                  accepted;
        logic                overflow_started;
        gf_field_pkg::byte_t exp_byte;
        clock            = 1'b0;
        rst_n            = 1'b0;
        valid            = 1'b0;
        data             = '0;
        decrypt          = 1'b0;
        hold             = 1'b0;
        partial_word     = '0;
        partial_bytes    = 0;
        rng_state        = 32'd80;
        accepted         = 0;
        overflow_started = 1'b0;
        $readmemh("dv/sbox_patterns.txt", patterns);
        for (int i = 0; i < NUM_LINES; i++) begin
            if ($isunknown(patterns[i*FIELDS]) || patterns[i*FIELDS] == 8'h00 ||
                patterns[i*FIELDS+1] > 8'h01) begin
                abort_run("Pattern file is missing or has a malformed line");
            end
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_LINES; i++) begin
            @(negedge clock);
            test     = int'(patterns[i*FIELDS]);
            exp_byte = patterns[i*FIELDS+3];
            // Overflow run starts from an empty FIFO
            if (test == OVERFLOW_TEST && !overflow_started) begin
                valid = 1'b0;
                hold  = 1'b0;
                wait_drained();
                check_value("back_pressure_flag", '0, {31'b0, overflow});
                overflow_started = 1'b1;
            end
            if (test == HOLD_TEST) begin
                rng_state = next_random(rng_state);
                hold      = (rng_state[2:0] < 3'd3);
            end else begin
                hold = (test == OVERFLOW_TEST);
            end
            valid   = 1'b1;
            data    = patterns[i*FIELDS+2];
            decrypt = patterns[i*FIELDS+1][0];
            if (test != OVERFLOW_TEST || accepted < gf_field_pkg::FIFO_DEPTH) begin
                expect_byte(test, exp_byte);
            end
            if (test == OVERFLOW_TEST) begin
                accepted++;
            end
        end
        @(negedge clock);
        valid = 1'b0;
        repeat (2) @(negedge clock);
        check_value("overflow_flag_set", 32'd1, {31'b0, overflow});
        hold = 1'b0;
        wait_drained();
        // Dropped bytes must never show up as an extra word
        repeat (20) @(negedge clock);
        check_value("overflow_flag_sticky", 32'd1, {31'b0, overflow});
        // Only a reset clears the overflow flag
        rst_n = 1'b0;
        @(negedge clock);
        check_value("overflow_flag_reset", '0, {31'b0, overflow});
        if (exp_words.size() != 0 || partial_bytes != 0) begin
            abort_run("Not all expected words were received");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/gf_field_pkg.sv
verilog/gf_2to4_multiplier.sv
verilog/multiplicative_inversion.sv
verilog/sbox_engine.sv
verilog/sub_bytes_fifo.sv
verilog/word_assembler.sv
verilog/sbox_subsystem_top.sv
dv/tb_sbox_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the S-box subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sbox_subsystem -f filelist.f

# Capture the output even when the simulation stops with an error
output=$(./obj_dir/Vtb_sbox_subsystem) || true
echo "$output"

echo "$output" | grep -q "^Test completed successfully$"

//--- verilog/gf_2to4_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module gf_2to4_multiplier #(
    parameter int PIPELINED = 1
) (
    input  wire                         i_clock,
    input  wire                         i_rst_n,
    input  wire gf_field_pkg::nibble_t  i_x,
    input  wire gf_field_pkg::nibble_t  i_y,
    output gf_field_pkg::nibble_t       o_prod
);

    gf_field_pkg::nibble_t prod;

    assign prod = gf_field_pkg::gf4_mul(i_x, i_y);

    generate
        if (PIPELINED != 0) begin : g_registered
            // One stage on the product
            always_ff @(posedge i_clock) begin
                if (!i_rst_n) begin
                    o_prod <= '0;
                end else begin
                    o_prod <= prod;
                end
            end
        end else begin : g_comb
            assign o_prod = prod;
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/gf_field_pkg.sv
`default_nettype none

package gf_field_pkg;

    localparam int NB_BYTE        = 8;
    localparam int NB_HALF_BYTE   = 4;
    localparam int NB_WORD        = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int FIFO_DEPTH     = 8;

    // Subfield over x^4 + x + 1 and extension over X^2 + X + LAMBDA
    localparam logic [NB_HALF_BYTE-1:0] LAMBDA       = 4'hC;
    localparam logic [NB_BYTE-1:0]      AFFINE_CONST = 8'h63;

    typedef logic [NB_BYTE-1:0]      byte_t;
    typedef logic [NB_HALF_BYTE-1:0] nibble_t;
    typedef logic [NB_WORD-1:0]      word_t;

    function automatic nibble_t gf4_mul(nibble_t x, nibble_t y);
        nibble_t acc;
        nibble_t a;
        acc = '0;
        a   = x;
        for (int i = 0; i < NB_HALF_BYTE; i++) begin
            if (y[i]) begin
                acc = acc ^ a;
            end
            // Shift by x, fold x^4 back as x + 1
            a = {a[NB_HALF_BYTE-2:0], 1'b0} ^ (a[NB_HALF_BYTE-1] ? 4'b0011 : 4'b0000);
        end
        return acc;
    endfunction

    function automatic nibble_t gf4_square(nibble_t x);
        return {x[3], x[3] ^ x[1], x[2], x[2] ^ x[0]};
    endfunction

    function automatic nibble_t gf4_mul_lambda(nibble_t x);
        return gf4_mul(x, LAMBDA);
    endfunction

    // Inverse as x^14 which keeps zero at zero
    function automatic nibble_t gf4_inverse(nibble_t x);
        nibble_t x2;
        nibble_t x4;
        nibble_t x8;
        x2 = gf4_square(x);
        x4 = gf4_square(x2);
        x8 = gf4_square(x4);
        return gf4_mul(gf4_mul(x2, x4), x8);
    endfunction

    // Product in GF((2^4)^2) with the high nibble as the coefficient of X
    function automatic byte_t gf8c_mul(byte_t a, byte_t b);
        nibble_t hh;
        hh = gf4_mul(a[NB_BYTE-1:NB_HALF_BYTE], b[NB_BYTE-1:NB_HALF_BYTE]);
        return {hh ^ gf4_mul(a[NB_BYTE-1:NB_HALF_BYTE], b[NB_HALF_BYTE-1:0])
                   ^ gf4_mul(a[NB_HALF_BYTE-1:0], b[NB_BYTE-1:NB_HALF_BYTE]),
                gf4_mul_lambda(hh) ^ gf4_mul(a[NB_HALF_BYTE-1:0], b[NB_HALF_BYTE-1:0])};
    endfunction

    // First root of x^8 + x^4 + x^3 + x + 1 found in the composite field
    function automatic byte_t aes_root();
        byte_t c;
        byte_t c2;
        byte_t c4;
        byte_t root;
        root = '0;
        for (int k = 2; k < 256; k++) begin
            c  = byte_t'(k);
            c2 = gf8c_mul(c, c);
            c4 = gf8c_mul(c2, c2);
            if (root == '0 &&
                (gf8c_mul(c4, c4) ^ c4 ^ gf8c_mul(c2, c) ^ c ^ 8'h01) == '0) begin
                root = c;
            end
        end
        return root;
    endfunction

    // Column i of a basis matrix sits at bits [8i +: 8]
    function automatic byte_t mat_apply(logic [NB_BYTE*NB_BYTE-1:0] m, byte_t b);
        byte_t r;
        r = '0;
        for (int i = 0; i < NB_BYTE; i++) begin
            if (b[i]) begin
                r = r ^ m[i*NB_BYTE +: NB_BYTE];
            end
        end
        return r;
    endfunction

    function automatic logic [NB_BYTE*NB_BYTE-1:0] build_iso_fwd();
        logic [NB_BYTE*NB_BYTE-1:0] m;
        byte_t                      beta;
        byte_t                      col;
        m    = '0;
        beta = aes_root();
        col  = 8'h01;
        for (int i = 0; i < NB_BYTE; i++) begin
            m[i*NB_BYTE +: NB_BYTE] = col;
            col = gf8c_mul(col, beta);
        end
        return m;
    endfunction

    function automatic logic [NB_BYTE*NB_BYTE-1:0] build_iso_inv(
        logic [NB_BYTE*NB_BYTE-1:0] fwd
    );
        logic [NB_BYTE*NB_BYTE-1:0] m;
        m = '0;
        for (int j = 0; j < NB_BYTE; j++) begin
            for (int a = 1; a < 256; a++) begin
                if (mat_apply(fwd, byte_t'(a)) == byte_t'(1 << j)) begin
                    m[j*NB_BYTE +: NB_BYTE] = byte_t'(a);
                end
            end
        end
        return m;
    endfunction

    localparam logic [NB_BYTE*NB_BYTE-1:0] ISO_FWD = build_iso_fwd();
    localparam logic [NB_BYTE*NB_BYTE-1:0] ISO_INV = build_iso_inv(ISO_FWD);

    function automatic byte_t iso_map(byte_t b);
        return mat_apply(ISO_FWD, b);
    endfunction

    function automatic byte_t iso_map_inv(byte_t b);
        return mat_apply(ISO_INV, b);
    endfunction

    function automatic byte_t rotl(byte_t b, int unsigned n);
        return byte_t'((b << n) | (b >> (NB_BYTE - n)));
    endfunction

    function automatic byte_t affine_fwd(byte_t b);
        return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4) ^ AFFINE_CONST;
    endfunction

    // Strip the constant, then the inverse linear part
    function automatic byte_t affine_inv(byte_t b);
        byte_t t;
        t = b ^ AFFINE_CONST;
        return rotl(t, 1) ^ rotl(t, 3) ^ rotl(t, 6);
    endfunction

endpackage

`default_nettype wire

//--- verilog/multiplicative_inversion.sv
`timescale 1ns/10ps
`default_nettype none

module multiplicative_inversion (
    input  wire                       i_clock,
    input  wire                       i_rst_n,
    input  wire gf_field_pkg::byte_t  i_data,
    output gf_field_pkg::byte_t       o_mult_inverse
);

    localparam int PIPELINED = 1;

    gf_field_pkg::byte_t   delta;
    gf_field_pkg::nibble_t delta_h;
    gf_field_pkg::nibble_t delta_l;
    gf_field_pkg::nibble_t delta_hl;
    gf_field_pkg::nibble_t xto2_lambda;
    gf_field_pkg::nibble_t prod;
    gf_field_pkg::nibble_t norm;
    gf_field_pkg::nibble_t inv_norm;
    gf_field_pkg::nibble_t prod2_1;
    gf_field_pkg::nibble_t prod2_2;

    // Into the composite field
    assign delta    = gf_field_pkg::iso_map(i_data);
    assign delta_h  = delta[gf_field_pkg::NB_BYTE-1:gf_field_pkg::NB_HALF_BYTE];
    assign delta_l  = delta[gf_field_pkg::NB_HALF_BYTE-1:0];
    assign delta_hl = delta_h ^ delta_l;

    assign xto2_lambda = gf_field_pkg::gf4_mul_lambda(gf_field_pkg::gf4_square(delta_h));

    gf_2to4_multiplier #(
        .PIPELINED (0)
    ) u_gf_2to4_multiplier1 (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_x     (delta_hl),
        .i_y     (delta_l),
        .o_prod  (prod)
    );

    // The subfield norm is the only value that needs a real inverse
    assign norm     = xto2_lambda ^ prod;
    assign inv_norm = gf_field_pkg::gf4_inverse(norm);

    gf_2to4_multiplier #(
        .PIPELINED (PIPELINED)
    ) u_gf_2to4_multiplier2_1 (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_x     (inv_norm),
        .i_y     (delta_h),
        .o_prod  (prod2_1)
    );

    gf_2to4_multiplier #(
        .PIPELINED (PIPELINED)
    ) u_gf_2to4_multiplier2_2 (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_x     (inv_norm),
        .i_y     (delta_hl),
        .o_prod  (prod2_2)
    );

    // Back to the AES polynomial basis
    assign o_mult_inverse = gf_field_pkg::iso_map_inv({prod2_1, prod2_2});

endmodule

`default_nettype wire

//--- verilog/sbox_engine.sv
`timescale 1ns/10ps
`default_nettype none

module sbox_engine (
    input  wire                       i_clock,
    input  wire                       i_rst_n,
    input  wire                       i_valid,
    input  wire gf_field_pkg::byte_t  i_data,
    input  wire                       i_decrypt,
    output logic                      o_valid,
    output gf_field_pkg::byte_t       o_data
);

    gf_field_pkg::byte_t inv_in;
    gf_field_pkg::byte_t inv_out;
    logic                valid_q;
    logic                decrypt_q;

    // Inverse S-box undoes the affine step first
    assign inv_in = i_decrypt ? gf_field_pkg::affine_inv(i_data) : i_data;

    multiplicative_inversion u_multiplicative_inversion (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_data         (inv_in),
        .o_mult_inverse (inv_out)
    );

    // Strobe and mode ride along with the inverter stage
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            valid_q   <= 1'b0;
            decrypt_q <= 1'b0;
        end else begin
            valid_q   <= i_valid;
            decrypt_q <= i_decrypt;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = decrypt_q ? inv_out : gf_field_pkg::affine_fwd(inv_out);

    a_valid_known : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        !$isunknown(o_valid)
    );

endmodule

`default_nettype wire

//--- verilog/sbox_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module sbox_subsystem_top (
    input  wire                       i_clock,
    input  wire                       i_rst_n,
    input  wire                       i_valid,
    input  wire gf_field_pkg::byte_t  i_data,
    input  wire                       i_decrypt,
    input  wire                       i_hold,
    output gf_field_pkg::word_t       o_word,
    output logic                      o_word_valid,
    output logic                      o_overflow
);

    logic                engine_valid;
    gf_field_pkg::byte_t engine_data;
    logic                rd_en;
    gf_field_pkg::byte_t fifo_rd_data;
    logic                fifo_empty;

    sbox_engine u_sbox_engine (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_valid),
        .i_data    (i_data),
        .i_decrypt (i_decrypt),
        .o_valid   (engine_valid),
        .o_data    (engine_data)
    );

    sub_bytes_fifo u_sub_bytes_fifo (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (engine_valid),
        .i_wr_data  (engine_data),
        .i_rd_en    (rd_en),
        .o_rd_data  (fifo_rd_data),
        .o_empty    (fifo_empty),
        .o_overflow (o_overflow)
    );

    word_assembler u_word_assembler (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_hold       (i_hold),
        .i_empty      (fifo_empty),
        .i_rd_data    (fifo_rd_data),
        .o_rd_en      (rd_en),
        .o_word       (o_word),
        .o_word_valid (o_word_valid)
    );

endmodule

`default_nettype wire

//--- verilog/sub_bytes_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sub_bytes_fifo (
    input  wire                       i_clock,
    input  wire                       i_rst_n,
    input  wire                       i_wr_en,
    input  wire gf_field_pkg::byte_t  i_wr_data,
    input  wire                       i_rd_en,
    output gf_field_pkg::byte_t       o_rd_data,
    output logic                      o_empty,
    output logic                      o_overflow
);

    localparam int DEPTH  = gf_field_pkg::FIFO_DEPTH;
    localparam int NB_PTR = $clog2(DEPTH);

    typedef logic [NB_PTR-1:0] ptr_t;
    typedef logic [NB_PTR:0]   count_t;

    gf_field_pkg::byte_t mem [DEPTH];
    ptr_t                wr_ptr;
    ptr_t                rd_ptr;
    count_t              count;
    logic                full;
    logic                do_wr;
    logic                do_rd;

    assign full    = (count == count_t'(DEPTH));
    assign o_empty = (count == '0);
    assign do_wr   = i_wr_en && !full;
    assign do_rd   = i_rd_en && !o_empty;

    // Head byte visible without a read cycle
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge i_clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            // A lost byte sets the flag until reset
            if (i_wr_en && full) begin
                o_overflow <= 1'b1;
            end
        end
    end

    a_no_read_empty : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_rd_en |-> !o_empty
    );

    a_count_bound : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        count <= count_t'(DEPTH)
    );

endmodule

`default_nettype wire

//--- verilog/word_assembler.sv
`timescale 1ns/10ps
`default_nettype none

module word_assembler (
    input  wire                       i_clock,
    input  wire                       i_rst_n,
    input  wire                       i_hold,
    input  wire                       i_empty,
    input  wire gf_field_pkg::byte_t  i_rd_data,
    output logic                      o_rd_en,
    output gf_field_pkg::word_t       o_word,
    output logic                      o_word_valid
);

    localparam int NB_CNT = $clog2(gf_field_pkg::BYTES_PER_WORD);

    typedef logic [NB_CNT-1:0] byte_cnt_t;

    gf_field_pkg::word_t shift_reg;
    gf_field_pkg::word_t next_word;
    byte_cnt_t           byte_cnt;

    assign o_rd_en = !i_empty && !i_hold;

    // Earlier bytes move up, newest enters at the bottom
    assign next_word = {shift_reg[gf_field_pkg::NB_WORD-gf_field_pkg::NB_BYTE-1:0], i_rd_data};

    always_ff @(posedge i_clock) begin
        if (o_rd_en) begin
            shift_reg <= next_word;
        end
        if (o_rd_en && byte_cnt == byte_cnt_t'(gf_field_pkg::BYTES_PER_WORD - 1)) begin
            o_word <= next_word;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            byte_cnt     <= '0;
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= o_rd_en &&
                            byte_cnt == byte_cnt_t'(gf_field_pkg::BYTES_PER_WORD - 1);
            if (o_rd_en) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    a_word_pulse : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_word_valid |=> !o_word_valid
    );

endmodule

`default_nettype wire
